//--- all.f
+incdir+rtl
rtl/issue_pkg.sv
rtl/int_regfile.sv
rtl/operand_hazard_check.sv
rtl/operand_select.sv
rtl/issue_ex_register.sv
rtl/issue_read_operands.sv
tests/tb_issue_read_operands.sv

//--- Makefile
# Verilator build and run of the issue stage testbench

VERILATOR ?= verilator
TOP       ?= tb_issue_read_operands
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES   := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, a missing result also counts as a failure
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAILED: see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "FAILED: no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_issue_read_operands.sv
/*
 * table-driven testbench for the issue and operand-read stage
 * each row takes one cycle with ack checked mid-cycle and the ID/EX outputs one cycle later
 * a mirror of the register file is kept from the commit writes
 */
`timescale 1ns/10ps
`default_nettype none

`include "issue_defines.svh"

module tb_issue_read_operands;

    import issue_pkg::*;

    localparam int  NUM_ROWS     = 25;
    localparam int  RESET_CYCLES = 16;
    localparam int  IDLE_TIMEOUT = 20;
    localparam op_t OP_ADD    = 7'd0;
    localparam op_t OP_MUL    = 7'd12;
    localparam op_t OP_LD     = 7'd20;
    localparam op_t OP_ST     = 7'd21;
    localparam op_t OP_BR     = 7'd30;
    localparam op_t OP_CSR    = 7'd40;
    localparam op_t OP_SFENCE = `ISSUE_OP_SFENCE_VMA;

    // one stimulus row with its expected response
    typedef struct packed {
        fu_t        fu;
        op_t        op;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic [3:0] flags;    // use_imm, use_zimm, use_pc, ex_valid
        fu_t        clob_rs1;
        fu_t        clob_rs2;
        fu_t        clob_rd;
        logic [3:0] env;      // rs1_valid, rs2_valid, flu_ready, lsu_ready
        logic [1:0] evt;      // commit to rd on port 1, flush
        logic       exp_ack;
        fu_t        exp_unit; // LOAD stands for the lsu strobe
    } row_t;

    logic         clk_i;
    logic         rst_i;
    logic         flush_i;
    issue_instr_t issue_instr_i;
    logic         issue_valid_i;
    logic         issue_ack_o;
    reg_addr_t    rs1_o;
    reg_addr_t    rs2_o;
    xlen_t        rs1_i;
    logic         rs1_valid_i;
    xlen_t        rs2_i;
    logic         rs2_valid_i;
    clobber_t     clobber_i;
    logic         flu_ready_i;
    logic         lsu_ready_i;
    commit_bus_t  commit_i;
    fu_data_t     fu_data_o;
    xlen_t        pc_o;
    logic         is_compressed_instr_o;
    logic         alu_valid_o;
    logic         branch_valid_o;
    logic         lsu_valid_o;
    logic         mult_valid_o;
    logic         csr_valid_o;

    row_t     rows [NUM_ROWS];
    xlen_t    ref_regs [`ISSUE_NR_REGS];
    fu_data_t exp_data;
    fu_data_t prev_data;
    fu_t      prev_unit;
    xlen_t    exp_pc;
    logic     exp_compressed;
    xlen_t    prev_pc;
    logic     prev_compressed;
    xlen_t    commit_data;
    int       row_idx;

    issue_read_operands i_issue_read_operands (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        stop_run($sformatf("[FAIL] %s in row %0d: got 0x%h, expected 0x%h",
                           name, row_idx, got, exp));
    endtask

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp) report_value("issue_ack_o", 32'(got), 32'(exp));
    endtask

    task automatic check_src_addr(input string name, input reg_addr_t got,
                                  input reg_addr_t exp);
        if (got !== exp) report_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_fu_data(input fu_data_t got, input fu_data_t exp);
        if (got.fu !== exp.fu) report_value("fu_data_o.fu", 32'(got.fu), 32'(exp.fu));
        if (got.op !== exp.op) report_value("fu_data_o.op", 32'(got.op), 32'(exp.op));
        if (got.operand_a !== exp.operand_a)
            report_value("fu_data_o.operand_a", got.operand_a, exp.operand_a);
        if (got.operand_b !== exp.operand_b)
            report_value("fu_data_o.operand_b", got.operand_b, exp.operand_b);
        if (got.imm !== exp.imm) report_value("fu_data_o.imm", got.imm, exp.imm);
        if (got.trans_id !== exp.trans_id)
            report_value("fu_data_o.trans_id", 32'(got.trans_id), 32'(exp.trans_id));
    endtask

    task automatic check_pc(input xlen_t got, input xlen_t exp);
        if (got !== exp) report_value("pc_o", got, exp);
    endtask

    task automatic check_compressed(input logic got, input logic exp);
        if (got !== exp) report_value("is_compressed_instr_o", 32'(got), 32'(exp));
    endtask

    task automatic check_unit(input fu_t got, input fu_t exp);
        if (got !== exp) report_value("unit valids", 32'(got), 32'(exp));
    endtask

    // one-hot unit strobes back to a unit code
    function automatic fu_t unit_from_valids();
        if (alu_valid_o) return ALU;
        if (branch_valid_o) return CTRL_FLOW;
        if (lsu_valid_o) return LOAD;
        if (mult_valid_o) return MULT;
        if (csr_valid_o) return CSR;
        return NONE;
    endfunction

    function automatic int valid_count();
        return int'(alu_valid_o) + int'(branch_valid_o) + int'(lsu_valid_o)
             + int'(mult_valid_o) + int'(csr_valid_o);
    endfunction

    task automatic check_outputs(input fu_t exp_unit, input fu_data_t exp,
                                 input xlen_t pc_exp, input logic c_exp);
        if (valid_count() > 1) stop_run("more than one unit valid is high in one cycle");
        check_unit(unit_from_valids(), exp_unit);
        // payload only matters when a unit takes it
        if (exp_unit != NONE) begin
            check_fu_data(fu_data_o, exp);
            check_pc(pc_o, pc_exp);
            check_compressed(is_compressed_instr_o, c_exp);
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic drive_idle();
        clobber_t clob;
        for (int i = 0; i < `ISSUE_NR_REGS; i++) clob[i] = NONE;
        issue_instr_i <= '0;
        issue_valid_i <= 1'b0;
        rs1_i         <= '0;
        rs2_i         <= '0;
        {rs1_valid_i, rs2_valid_i, flu_ready_i, lsu_ready_i} <= 4'b0011;
        clobber_i     <= clob;
        commit_i      <= '0;
        flush_i       <= 1'b0;
    endtask

    // random contents for x1 and up using all commit ports per cycle
    task automatic preload_regs();
        commit_bus_t cmt;
        for (int i = 1; i < `ISSUE_NR_REGS; i += `ISSUE_NR_COMMIT) begin
            cmt = '0;
            for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
                if (i + p < `ISSUE_NR_REGS) begin
                    cmt[p].we       = 1'b1;
                    cmt[p].waddr    = reg_addr_t'(i + p);
                    cmt[p].wdata    = $urandom();
                    ref_regs[i + p] = cmt[p].wdata;
                end
            end
            @(posedge clk_i);
            commit_i <= cmt;
        end
        @(posedge clk_i);
        commit_i <= '0;
    endtask

    task automatic wait_units_idle(input int max_cycles);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (valid_count() != 0) begin
            if (waited >= max_cycles) stop_run("timeout while waiting for the unit valids to drop");
            waited++;
            @(negedge clk_i);
        end
    endtask

    task automatic apply_row(input row_t r);
        issue_instr_t ins;
        clobber_t     clob;
        commit_bus_t  cmt;
        xlen_t        sb_a;
        xlen_t        sb_b;
        logic         fwd_a;
        logic         fwd_b;
        ins               = '0;
        ins.pc            = $urandom();
        ins.trans_id      = trans_id_t'($urandom());
        ins.fu            = r.fu;
        ins.op            = r.op;
        ins.rs1           = r.rs1;
        ins.rs2           = r.rs2;
        ins.rd            = r.rd;
        ins.result        = $urandom();
        ins.is_compressed = 1'($urandom());
        {ins.use_imm, ins.use_zimm, ins.use_pc, ins.ex_valid} = r.flags;
        sb_a        = $urandom();
        sb_b        = $urandom();
        commit_data = $urandom();
        for (int i = 0; i < `ISSUE_NR_REGS; i++) clob[i] = NONE;
        clob[r.rd]  = r.clob_rd;
        clob[r.rs2] = r.clob_rs2;
        clob[r.rs1] = r.clob_rs1;
        cmt = '0;
        if (r.evt[1]) begin
            cmt[1].we    = 1'b1;
            cmt[1].waddr = r.rd;
            cmt[1].wdata = commit_data;
        end
        // valid scoreboard values forward unless a csr writes them outside sfence
        fwd_a = !ins.use_zimm && (r.clob_rs1 != NONE) && r.env[3]
                && ((r.clob_rs1 != CSR) || (r.op == OP_SFENCE));
        fwd_b = (r.clob_rs2 != NONE) && r.env[2]
                && ((r.clob_rs2 != CSR) || (r.op == OP_SFENCE));
        exp_data.fu        = r.fu;
        exp_data.op        = r.op;
        exp_data.trans_id  = ins.trans_id;
        exp_data.imm       = ins.result;
        exp_data.operand_a = ref_regs[r.rs1];
        if (fwd_a) exp_data.operand_a = sb_a;
        if (ins.use_pc) exp_data.operand_a = ins.pc;
        if (ins.use_zimm) exp_data.operand_a = xlen_t'(r.rs1);
        exp_data.operand_b = ref_regs[r.rs2];
        if (fwd_b) exp_data.operand_b = sb_b;
        if (ins.use_imm && (r.fu != STORE) && (r.fu != CTRL_FLOW))
            exp_data.operand_b = ins.result;
        exp_pc         = ins.pc;
        exp_compressed = ins.is_compressed;
        issue_instr_i <= ins;
        issue_valid_i <= 1'b1;
        rs1_i         <= sb_a;
        rs2_i         <= sb_b;
        {rs1_valid_i, rs2_valid_i, flu_ready_i, lsu_ready_i} <= r.env;
        clobber_i     <= clob;
        commit_i      <= cmt;
        flush_i       <= r.evt[0];
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------
    task automatic fill_table();
        // plain issue to each unit without clobbers
        rows[0]  = '{ALU, OP_ADD, 5'd1, 5'd2, 5'd3, 4'b0000,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, ALU};
        rows[1]  = '{ALU, OP_ADD, 5'd4, 5'd5, 5'd6, 4'b1000,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, ALU};
        rows[2]  = '{LOAD, OP_LD, 5'd7, 5'd8, 5'd9, 4'b1000,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, LOAD};
        rows[3]  = '{STORE, OP_ST, 5'd10, 5'd11, 5'd12, 4'b1000,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, LOAD};
        rows[4]  = '{CSR, OP_CSR, 5'd13, 5'd0, 5'd14, 4'b0100,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, CSR};
        rows[5]  = '{CTRL_FLOW, OP_BR, 5'd15, 5'd16, 5'd17, 4'b1010,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, CTRL_FLOW};
        // forwarding then stalls on invalid or csr-owned sources
        rows[6]  = '{ALU, OP_ADD, 5'd1, 5'd2, 5'd18, 4'b0000,
                     LOAD, NONE, NONE, 4'b1011, 2'b00, 1'b1, ALU};
        rows[7]  = '{ALU, OP_ADD, 5'd3, 5'd4, 5'd19, 4'b0000,
                     NONE, MULT, NONE, 4'b0111, 2'b00, 1'b1, ALU};
        rows[8]  = '{ALU, OP_ADD, 5'd5, 5'd6, 5'd21, 4'b0000,
                     ALU, NONE, NONE, 4'b0011, 2'b00, 1'b0, NONE};
        rows[9]  = '{ALU, OP_ADD, 5'd7, 5'd8, 5'd21, 4'b0000,
                     CSR, NONE, NONE, 4'b1011, 2'b00, 1'b0, NONE};
        rows[10] = '{CSR, OP_SFENCE, 5'd9, 5'd10, 5'd0, 4'b0000,
                     CSR, CSR, NONE, 4'b1111, 2'b00, 1'b1, CSR};
        // zimm ignores whoever owns the rs1 field
        rows[11] = '{CSR, OP_CSR, 5'd11, 5'd12, 5'd22, 4'b0100,
                     ALU, NONE, NONE, 4'b0011, 2'b00, 1'b1, CSR};
        // waw on rd released by a commit in the same cycle
        rows[12] = '{ALU, OP_ADD, 5'd5, 5'd6, 5'd20, 4'b0000,
                     NONE, NONE, ALU, 4'b0011, 2'b00, 1'b0, NONE};
        rows[13] = '{ALU, OP_ADD, 5'd5, 5'd6, 5'd20, 4'b0000,
                     NONE, NONE, ALU, 4'b0011, 2'b10, 1'b1, ALU};
        rows[14] = '{ALU, OP_ADD, 5'd20, 5'd1, 5'd23, 4'b0000,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, ALU};
        // busy units then the exception and fu NONE overrides
        rows[15] = '{ALU, OP_ADD, 5'd2, 5'd3, 5'd24, 4'b0000,
                     NONE, NONE, NONE, 4'b0001, 2'b00, 1'b0, NONE};
        rows[16] = '{LOAD, OP_LD, 5'd4, 5'd5, 5'd25, 4'b1000,
                     NONE, NONE, NONE, 4'b0010, 2'b00, 1'b0, NONE};
        rows[17] = '{ALU, OP_ADD, 5'd6, 5'd7, 5'd26, 4'b0001,
                     NONE, NONE, NONE, 4'b0001, 2'b00, 1'b1, NONE};
        rows[18] = '{NONE, OP_ADD, 5'd8, 5'd9, 5'd27, 4'b0000,
                     NONE, NONE, ALU, 4'b0011, 2'b00, 1'b1, NONE};
        // mult back to back then one refused non-mult
        rows[19] = '{MULT, OP_MUL, 5'd10, 5'd11, 5'd28, 4'b0000,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, MULT};
        rows[20] = '{MULT, OP_MUL, 5'd12, 5'd13, 5'd29, 4'b0000,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, MULT};
        rows[21] = '{ALU, OP_ADD, 5'd14, 5'd15, 5'd30, 4'b0000,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b0, NONE};
        rows[22] = '{ALU, OP_ADD, 5'd14, 5'd15, 5'd30, 4'b0000,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, ALU};
        // flush drops the strobe but not the ack
        rows[23] = '{ALU, OP_ADD, 5'd16, 5'd17, 5'd31, 4'b0000,
                     NONE, NONE, NONE, 4'b0011, 2'b01, 1'b1, NONE};
        rows[24] = '{LOAD, OP_LD, 5'd18, 5'd19, 5'd1, 4'b1000,
                     NONE, NONE, NONE, 4'b0011, 2'b00, 1'b1, LOAD};
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        fu_data_t zero_data;
        void'($urandom(32'hedcd));
        fill_table();
        for (int i = 0; i < `ISSUE_NR_REGS; i++) ref_regs[i] = '0;
        row_idx = -1;
        rst_i   <= 1'b1;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        // payload holds its reset value under idle input
        wait_units_idle(IDLE_TIMEOUT);
        zero_data    = '0;
        zero_data.fu = NONE;
        check_fu_data(fu_data_o, zero_data);
        preload_regs();
        prev_unit       = NONE;
        prev_data       = zero_data;
        prev_pc         = '0;
        prev_compressed = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk_i);
            apply_row(rows[r]);
            @(negedge clk_i);
            // outputs now belong to the previous row
            row_idx = r - 1;
            check_outputs(prev_unit, prev_data, prev_pc, prev_compressed);
            row_idx = r;
            check_ack(issue_ack_o, rows[r].exp_ack);
            check_src_addr("rs1_o", rs1_o, rows[r].rs1);
            check_src_addr("rs2_o", rs2_o, rows[r].rs2);
            // commit lands at the coming edge
            if (rows[r].evt[1] && (rows[r].rd != '0)) ref_regs[rows[r].rd] = commit_data;
            prev_unit       = rows[r].exp_unit;
            prev_data       = exp_data;
            prev_pc         = exp_pc;
            prev_compressed = exp_compressed;
        end
        @(posedge clk_i);
        drive_idle();
        @(negedge clk_i);
        row_idx = NUM_ROWS - 1;
        check_outputs(prev_unit, prev_data, prev_pc, prev_compressed);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/issue_read_operands.sv
/*
 * issue and operand-read stage, integer only, single issue
 * ack is combinational, the upstream holds the instruction until acked
 * fu_data_o and one unit valid follow one cycle after dispatch
 */
`timescale 1ns/10ps
`default_nettype none

module issue_read_operands (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    flush_i,
    // scoreboard issue port
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  logic                    issue_valid_i,
    output logic                    issue_ack_o,
    // scoreboard operand lookup
    output issue_pkg::reg_addr_t    rs1_o,
    output issue_pkg::reg_addr_t    rs2_o,
    input  issue_pkg::xlen_t        rs1_i,
    input  logic                    rs1_valid_i,
    input  issue_pkg::xlen_t        rs2_i,
    input  logic                    rs2_valid_i,
    input  issue_pkg::clobber_t     clobber_i,
    // unit readiness
    input  logic                    flu_ready_i,
    input  logic                    lsu_ready_i,
    // write back
    input  issue_pkg::commit_bus_t  commit_i,
    // towards execute
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::xlen_t        pc_o,
    output logic                    is_compressed_instr_o,
    output logic                    alu_valid_o,
    output logic                    branch_valid_o,
    output logic                    lsu_valid_o,
    output logic                    mult_valid_o,
    output logic                    csr_valid_o
);

    import issue_pkg::*;

    fwd_sel_t fwd;
    xlen_t    rf_a, rf_b;
    xlen_t    operand_a, operand_b, imm;
    logic     dispatch;
    logic     mult_pending;

    // scoreboard is polled with the raw source fields
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    int_regfile i_int_regfile (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b),
        .commit_i  (commit_i)
    );

    operand_hazard_check i_operand_hazard_check (
        .issue_instr_i, .issue_valid_i, .rs1_valid_i, .rs2_valid_i,
        .clobber_i, .commit_i, .flu_ready_i, .lsu_ready_i,
        .mult_pending_i (mult_pending),
        .fwd_o          (fwd),
        .issue_ack_o,
        .dispatch_o     (dispatch)
    );

    operand_select i_operand_select (
        .issue_instr_i, .rs1_i, .rs2_i,
        .rf_a_i (rf_a), .rf_b_i (rf_b), .fwd_i (fwd),
        .operand_a_o (operand_a), .operand_b_o (operand_b), .imm_o (imm)
    );

    issue_ex_register i_issue_ex_register (
        .clk_i, .rst_i, .flush_i, .issue_instr_i,
        .dispatch_i      (dispatch),
        .operand_a_i     (operand_a),
        .operand_b_i     (operand_b),
        .imm_i           (imm),
        .fu_data_o, .pc_o,
        .is_compressed_o (is_compressed_instr_o),
        .alu_valid_o, .branch_valid_o, .lsu_valid_o, .mult_valid_o, .csr_valid_o,
        .mult_pending_o  (mult_pending)
    );

endmodule

`default_nettype wire

//--- rtl/issue_ex_register.sv
/*
 * ID/EX pipeline register, the payload is loaded every cycle
 * a unit valid is a one-cycle strobe, there is no back-pressure here
 */
`timescale 1ns/10ps
`default_nettype none

module issue_ex_register (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    flush_i,
    input  logic                    dispatch_i,
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  issue_pkg::xlen_t        operand_a_i,
    input  issue_pkg::xlen_t        operand_b_i,
    input  issue_pkg::xlen_t        imm_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::xlen_t        pc_o,
    output logic                    is_compressed_o,
    output logic                    alu_valid_o,
    output logic                    branch_valid_o,
    output logic                    lsu_valid_o,
    output logic                    mult_valid_o,
    output logic                    csr_valid_o,
    output logic                    mult_pending_o
);

    import issue_pkg::*;

    logic alu_d, branch_d, lsu_d, mult_d, csr_d;

    // ------------------------------------------------------------
    // unit decode, suppressed on flush
    // ------------------------------------------------------------
    always_comb begin : unit_decode
        alu_d    = 1'b0;
        branch_d = 1'b0;
        lsu_d    = 1'b0;
        mult_d   = 1'b0;
        csr_d    = 1'b0;
        if (dispatch_i && !flush_i) begin
            case (issue_instr_i.fu)
                ALU:         alu_d    = 1'b1;
                CTRL_FLOW:   branch_d = 1'b1;
                LOAD, STORE: lsu_d    = 1'b1;
                MULT:        mult_d   = 1'b1;
                CSR:         csr_d    = 1'b1;
                default:     alu_d    = 1'b0; // NONE raises no strobe
            endcase
        end
    end

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fu_data_o       <= '0;
            fu_data_o.fu    <= NONE;
            pc_o            <= '0;
            is_compressed_o <= 1'b0;
            alu_valid_o     <= 1'b0;
            branch_valid_o  <= 1'b0;
            lsu_valid_o     <= 1'b0;
            mult_valid_o    <= 1'b0;
            csr_valid_o     <= 1'b0;
        end else begin
            fu_data_o.fu        <= issue_instr_i.fu;
            fu_data_o.op        <= issue_instr_i.op;
            fu_data_o.operand_a <= operand_a_i;
            fu_data_o.operand_b <= operand_b_i;
            fu_data_o.imm       <= imm_i;
            fu_data_o.trans_id  <= issue_instr_i.trans_id;
            pc_o                <= issue_instr_i.pc;
            is_compressed_o     <= issue_instr_i.is_compressed;
            alu_valid_o         <= alu_d;
            branch_valid_o      <= branch_d;
            lsu_valid_o         <= lsu_d;
            mult_valid_o        <= mult_d;
            csr_valid_o         <= csr_d;
        end
    end

    // mult in execute blocks other units for one cycle
    assign mult_pending_o = mult_valid_o;

endmodule

`default_nettype wire

//--- rtl/operand_select.sv
/*
 * operand multiplexers in front of the ID/EX register
 * stores and branches keep rs2 on operand b, their immediate goes via imm
 */
`timescale 1ns/10ps
`default_nettype none

`include "issue_defines.svh"

module operand_select (
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  issue_pkg::xlen_t        rf_a_i,
    input  issue_pkg::xlen_t        rf_b_i,
    input  issue_pkg::xlen_t        rs1_i,
    input  issue_pkg::xlen_t        rs2_i,
    input  issue_pkg::fwd_sel_t     fwd_i,
    output issue_pkg::xlen_t        operand_a_o,
    output issue_pkg::xlen_t        operand_b_o,
    output issue_pkg::xlen_t        imm_o
);

    import issue_pkg::*;

    xlen_t zimm;

    // rs1 field zero extended
    assign zimm = {{(`ISSUE_XLEN-`ISSUE_REG_ADDR_W){1'b0}}, issue_instr_i.rs1};

    // ------------------------------------------------------------
    // later assignments have higher priority
    // ------------------------------------------------------------
    always_comb begin : select_a
        operand_a_o = rf_a_i;
        if (fwd_i.fwd_rs1) operand_a_o = rs1_i;
        if (issue_instr_i.use_pc) operand_a_o = issue_instr_i.pc;
        if (issue_instr_i.use_zimm) operand_a_o = zimm;
    end

    always_comb begin : select_b
        operand_b_o = rf_b_i;
        if (fwd_i.fwd_rs2) operand_b_o = rs2_i;
        if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE)
                && (issue_instr_i.fu != CTRL_FLOW)) begin
            operand_b_o = issue_instr_i.result;
        end
    end

    // store offset or branch target always travels on imm
    assign imm_o = issue_instr_i.result;

endmodule

`default_nettype wire

//--- rtl/operand_hazard_check.sv
/*
 * hazard checks for the instruction at the head of the scoreboard
 * decides forwarding per source and raises the combinational issue ack
 * rs1 is not looked at when it carries a zimm
 */
`timescale 1ns/10ps
`default_nettype none

`include "issue_defines.svh"

module operand_hazard_check (
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  logic                    issue_valid_i,
    input  logic                    rs1_valid_i,
    input  logic                    rs2_valid_i,
    input  issue_pkg::clobber_t     clobber_i,
    input  issue_pkg::commit_bus_t  commit_i,
    input  logic                    flu_ready_i,
    input  logic                    lsu_ready_i,
    input  logic                    mult_pending_i,
    output issue_pkg::fwd_sel_t     fwd_o,
    output logic                    issue_ack_o,
    output logic                    dispatch_o
);

    import issue_pkg::*;

    fu_t  rs1_owner;
    fu_t  rs2_owner;
    fu_t  rd_owner;
    logic sfence;
    logic stall;
    logic fu_busy;
    logic rd_committing;

    // unit that will write each register
    assign rs1_owner = clobber_i[issue_instr_i.rs1];
    assign rs2_owner = clobber_i[issue_instr_i.rs2];
    assign rd_owner  = clobber_i[issue_instr_i.rd];
    assign sfence    = (issue_instr_i.op == `ISSUE_OP_SFENCE_VMA);

    // ------------------------------------------------------------
    // source operands
    // ------------------------------------------------------------
    always_comb begin : source_check
        stall = 1'b0;
        fwd_o = '0;
        // zimm is an immediate, nothing to wait on
        if (!issue_instr_i.use_zimm && (rs1_owner != NONE)) begin
            // csr results only reach us through the register file
            if (rs1_valid_i && ((rs1_owner != CSR) || sfence)) begin
                fwd_o.fwd_rs1 = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rs2_owner != NONE) begin
            if (rs2_valid_i && ((rs2_owner != CSR) || sfence)) begin
                fwd_o.fwd_rs2 = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // busy flag of the unit this instruction needs
    always_comb begin : unit_busy
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // waw is resolved when rd is written back this very cycle
    always_comb begin : waw_commit
        rd_committing = 1'b0;
        for (int unsigned i = 0; i < `ISSUE_NR_COMMIT; i++) begin
            if (commit_i[i].we && (commit_i[i].waddr == issue_instr_i.rd)) begin
                rd_committing = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // issue acknowledge
    // ------------------------------------------------------------
    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && ((rd_owner == NONE) || rd_committing)) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instructions need no operands
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // the fixed latency bus is taken by the mult issued last cycle
        if (mult_pending_i && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // excepted instructions retire without reaching a unit
    assign dispatch_o = issue_ack_o & ~issue_instr_i.ex_valid;

endmodule

`default_nettype wire

//--- rtl/int_regfile.sv
/*
 * integer register file, reads are combinational, writes land at the edge
 * x0 is never written and reads as zero
 * same-register writes on one edge: the highest commit port wins
 */
`timescale 1ns/10ps
`default_nettype none

`include "issue_defines.svh"

module int_regfile (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  issue_pkg::reg_addr_t raddr_a_i,
    input  issue_pkg::reg_addr_t raddr_b_i,
    output issue_pkg::xlen_t     rdata_a_o,
    output issue_pkg::xlen_t     rdata_b_o,
    input  issue_pkg::commit_bus_t commit_i
);

    import issue_pkg::*;

    // storage, entry 0 only ever holds its reset value
    xlen_t [`ISSUE_NR_REGS-1:0] regs_q;

    // ------------------------------------------------------------
    // write ports
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            regs_q <= '0;
        end else begin
            // later iterations override earlier ones
            for (int unsigned i = 0; i < `ISSUE_NR_COMMIT; i++) begin
                if (commit_i[i].we && (commit_i[i].waddr != '0)) begin
                    regs_q[commit_i[i].waddr] <= commit_i[i].wdata;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------
    // no write-to-read bypass, a commit is seen from the next cycle on
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- rtl/issue_pkg.sv
/*
 * types shared across the issue stage
 * fu_t encodes NONE as zero, a cleared register therefore reads as NONE
 */
`default_nettype none

`include "issue_defines.svh"

package issue_pkg;

    typedef logic [`ISSUE_XLEN-1:0]       xlen_t;
    typedef logic [`ISSUE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ISSUE_TRANS_ID_W-1:0] trans_id_t;
    typedef logic [`ISSUE_OP_W-1:0]       op_t;

    // functional unit, either the writer of a register or the unit needed
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        LOAD,
        STORE,
        MULT,
        CSR
    } fu_t;

    // one entry per architectural register
    typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_t;

    // ------------------------------------------------------------
    // instruction as handed over by the scoreboard
    // ------------------------------------------------------------
    typedef struct packed {
        xlen_t     pc;
        trans_id_t trans_id;
        fu_t       fu;
        op_t       op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     result;        // immediate
        logic      use_imm;
        logic      use_zimm;
        logic      use_pc;
        logic      ex_valid;      // exception already raised
        logic      is_compressed;
    } issue_instr_t;

    // payload towards the execute units
    typedef struct packed {
        fu_t       fu;
        op_t       op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } commit_port_t;

    typedef commit_port_t [`ISSUE_NR_COMMIT-1:0] commit_bus_t;

    // forward select per source operand
    typedef struct packed {
        logic fwd_rs1;
        logic fwd_rs2;
    } fwd_sel_t;

endpackage

`default_nettype wire

//--- rtl/issue_defines.svh
/*
 * widths and counts shared by the issue stage and its testbench
 * NR_COMMIT may grow, the regfile write loop scales with it
 */
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// data path and register addressing
`define ISSUE_XLEN          32
`define ISSUE_REG_ADDR_W    5
`define ISSUE_NR_REGS       32

// scoreboard slot id and operator code widths
`define ISSUE_TRANS_ID_W    3
`define ISSUE_OP_W          7

// commit ports writing the integer register file
`define ISSUE_NR_COMMIT     2

// csr-unit operation allowed to forward over a csr clobber
`define ISSUE_OP_SFENCE_VMA 7'd45

`endif
